//--- compile.f
verilog/dbg_cmd_pkg.sv
verilog/dbg_bus_pkg.sv
verilog/dbg_cmd_decode.sv
verilog/dbg_burst_ctrl.sv
verilog/dbg_burst_counters.sv
verilog/dbg_crc32.sv
verilog/dbg_result_out.sv
verilog/dbg_bus_module.sv
verif/tb_bus_mem.sv
verif/tb_dbg_bus_module.sv

//--- verif/tb_bus_mem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_bus_mem #(
	parameter int WORDS = 256,
	parameter int LATENCY = 3,
	parameter logic [31:0] ERR_ADDR = 32'hFFF0
) (
	input  logic tck_i,
	input  logic trstn_i,
	input  dbg_bus_pkg::bus_req_t bus_req_i,
	output dbg_bus_pkg::bus_rsp_t bus_rsp_o
);
	import dbg_bus_pkg::*;

	localparam int IDX_BITS = $clog2(WORDS);

	bus_data_t mem [WORDS];
	bus_req_t req_q;
	int wait_q;
	logic [IDX_BITS-1:0] idx;
	logic [1:0] offset;

	assign idx = req_q.addr[2 +: IDX_BITS];
	assign offset = req_q.addr[1:0];

	always_ff @(posedge tck_i or negedge trstn_i) begin
		if (!trstn_i) begin
			bus_rsp_o <= '{ready: 1'b1, err: 1'b0, rdata: '0};
			req_q <= '0;
			wait_q <= 0;
			for (int w = 0; w < WORDS; w++) begin
				mem[w] <= bus_data_t'(w + 1) * 32'h9E37_79B9; // Every address bit changes the word
			end
		end else if (bus_req_i.strobe) begin
			bus_rsp_o.ready <= 1'b0; // Falls the cycle after the strobe
			bus_rsp_o.err <= 1'b0;
			req_q <= bus_req_i;
			wait_q <= LATENCY - 1;
		end else if (!bus_rsp_o.ready) begin
			if (wait_q == 0) begin
				bus_rsp_o.ready <= 1'b1;
				bus_rsp_o.err <= req_q.addr == ERR_ADDR;
				bus_rsp_o.rdata <= mem[idx] >> (8 * offset); // Right-justified read word
				if (req_q.write) begin
					for (int b = 0; b < 4; b++) begin
						if (b >= offset && b < offset + req_q.size) begin
							mem[idx][8*b +: 8] <= req_q.wdata[8*(b-offset) +: 8];
						end
					end
				end
			end else begin
				wait_q <= wait_q - 1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verif/tb_dbg_bus_module.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dbg_bus_module;
	import dbg_cmd_pkg::*;
	import dbg_bus_pkg::*;

	localparam logic [31:0] CRC32_REFLECTED = 32'hEDB88320;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
	localparam logic [31:0] LFSR_SEED = 32'd96;
	localparam tap_ctl_t TAP_IDLE = 4'b0001;
	localparam tap_ctl_t TAP_CAP = 4'b1001;
	localparam tap_ctl_t TAP_SHIFT = 4'b0101;
	localparam tap_ctl_t TAP_UPD = 4'b0011;
	localparam logic [31:0] WR_ADDR = 32'h100;
	localparam logic [31:0] ERR_ADDR = 32'hFFF0;
	localparam int WR_WORDS = 4;
	localparam int READY_TRIES = 16;
	localparam int READOUT_CYCLES = 40;
	localparam int WRITE_CYCLES = 170;
	localparam int READ_CYCLES = 80;
	localparam int CYCLE_LIMIT = 2 * (3 * READOUT_CYCLES + 2 * WRITE_CYCLES + 3 * READ_CYCLES);

	logic tck_i = 1'b0;
	logic trstn;
	logic tdi;
	tap_ctl_t tap;
	logic [DR_WIDTH-1:0] dr;
	bus_rsp_t bus_rsp;
	bus_req_t bus_req;
	logic module_tdo;
	logic top_inhibit;

	logic [31:0] lfsr = LFSR_SEED;
	logic [31:0] wr_words [WR_WORDS];
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycles = 0;

	dbg_bus_module u_dut (
		.tck_i(tck_i),
		.trstn_i(trstn),
		.tdi_i(tdi),
		.tap_i(tap),
		.data_register_i(dr),
		.bus_rsp_i(bus_rsp),
		.module_tdo_o(module_tdo),
		.top_inhibit_o(top_inhibit),
		.bus_req_o(bus_req)
	);

	tb_bus_mem #(.WORDS(256), .LATENCY(3), .ERR_ADDR(ERR_ADDR)) u_mem (
		.tck_i(tck_i),
		.trstn_i(trstn),
		.bus_req_i(bus_req),
		.bus_rsp_o(bus_rsp)
	);

	always #5 tck_i = ~tck_i;

	always @(posedge tck_i) begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles without reaching the end of the tests", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] crc_update(input logic [31:0] crc, input logic b);
		logic fb;
		fb = crc[0] ^ b;
		crc_update = (crc >> 1) ^ (fb ? CRC32_REFLECTED : 32'h0);
	endfunction

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? (s >> 1) ^ LFSR_TAPS : s >> 1;
	endfunction

	function automatic logic [63:0] make_command(input op_t op, input logic [31:0] addr,
			input logic [15:0] count);
		make_command = {1'b0, op, addr, count, 11'h0};
	endfunction

	// Little-endian memory bytes at the access address, right-justified to the access size
	function automatic logic [31:0] expected_read(input logic [31:0] addr, input int nbits);
		logic [31:0] word;
		word = u_mem.mem[addr[9:2]] >> (8 * addr[1:0]);
		expected_read = (nbits == 32) ? word : word & ((32'h1 << nbits) - 32'h1);
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		$display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
		errors++;
	endtask

	task automatic close_test(input string name, input int errs_at_start);
		tests_run++;
		if (errors != errs_at_start) begin
			tests_failed++;
		end
		$display("%-26s %s", name, (errors != errs_at_start) ? "FAILED" : "ok");
	endtask

	// One TCK cycle of the host TAP, the data register shifts tdi in at bit 63
	task automatic tick(input tap_ctl_t t, input logic b, output logic tdo_bit);
		@(posedge tck_i);
		if (tap.shift && tap.select) begin
			dr <= {tdi, dr[DR_WIDTH-1:1]};
		end
		tap <= t;
		tdi <= b;
		@(negedge tck_i);
		tdo_bit = module_tdo;
	endtask

	task automatic send_command(input logic [63:0] cmd);
		@(posedge tck_i);
		dr <= cmd; // Host has already shifted the command in
		tap <= TAP_UPD;
		tdi <= 1'b0;
		@(negedge tck_i);
	endtask

	task automatic shift_error_reg(output logic [ERR_REG_WIDTH-1:0] val);
		logic tdo_bit;
		tick(TAP_CAP, 1'b0, tdo_bit);
		for (int i = 0; i < ERR_REG_WIDTH; i++) begin
			tick(TAP_SHIFT, 1'b0, tdo_bit);
			val[i] = tdo_bit;
		end
		tick(TAP_IDLE, 1'b0, tdo_bit);
	endtask

	task automatic fill_write_words();
		for (int w = 0; w < WR_WORDS; w++) begin
			for (int b = 0; b < 32; b++) begin
				wr_words[w][b] = lfsr[0];
				lfsr = lfsr_next(lfsr);
			end
		end
	endtask

	task automatic write_burst(input logic [31:0] addr, input logic [31:0] crc_flip,
			output logic match);
		logic [31:0] crc;
		logic tdo_bit;
		crc = '1;
		for (int w = 0; w < WR_WORDS; w++) begin
			for (int b = 0; b < 32; b++) begin
				crc = crc_update(crc, wr_words[w][b]);
			end
		end
		crc = crc ^ crc_flip;
		send_command(make_command(OP_BWRITE32, addr, 16'(WR_WORDS)));
		tick(TAP_IDLE, 1'b0, tdo_bit);
		tick(TAP_CAP, 1'b0, tdo_bit);
		tick(TAP_SHIFT, 1'b1, tdo_bit); // Start bit
		for (int w = 0; w < WR_WORDS; w++) begin
			for (int b = 0; b < 32; b++) begin
				tick(TAP_SHIFT, wr_words[w][b], tdo_bit);
			end
		end
		for (int i = 0; i < CRC_BITS; i++) begin
			tick(TAP_SHIFT, crc[i], tdo_bit);
		end
		tick(TAP_IDLE, 1'b0, match); // CRC now sits in bits 63..32
		if (top_inhibit !== 1'b1) begin
			report_mismatch("top_inhibit_o", top_inhibit, 1);
		end
		tick(TAP_UPD, 1'b0, tdo_bit);
		tick(TAP_IDLE, 1'b0, tdo_bit);
		if (top_inhibit !== 1'b0) begin
			report_mismatch("top_inhibit_o", top_inhibit, 0);
		end
	endtask

	task automatic read_burst(input op_t op, input logic [31:0] addr, input int count,
			input int nbits);
		logic [31:0] crc_exp;
		logic [31:0] crc_got;
		logic [31:0] exp_word;
		logic [31:0] got_word;
		logic tdo_bit;
		int tries;
		crc_exp = '1;
		crc_got = '0;
		tries = 0;
		send_command(make_command(op, addr, 16'(count)));
		tick(TAP_IDLE, 1'b0, tdo_bit);
		tick(TAP_CAP, 1'b0, tdo_bit);
		tick(TAP_SHIFT, 1'b0, tdo_bit);
		while (tdo_bit !== 1'b1 && tries < READY_TRIES) begin
			tick(TAP_SHIFT, 1'b0, tdo_bit);
			tries++;
		end
		if (tdo_bit !== 1'b1) begin
			$display("Read at 0x%0h never showed bus ready on TDO", addr);
			errors++;
		end
		if (top_inhibit !== 1'b1) begin
			report_mismatch("top_inhibit_o", top_inhibit, 1);
		end
		for (int w = 0; w < count; w++) begin
			exp_word = expected_read(addr + w * (nbits / 8), nbits);
			got_word = '0;
			for (int b = 0; b < nbits; b++) begin
				tick(TAP_SHIFT, 1'b0, tdo_bit);
				got_word[b] = tdo_bit;
				crc_exp = crc_update(crc_exp, exp_word[b]);
			end
			if (got_word !== exp_word) begin
				report_mismatch($sformatf("module_tdo_o read word %0d", w), got_word,
					exp_word);
			end
		end
		for (int i = 0; i < CRC_BITS; i++) begin
			tick(TAP_SHIFT, 1'b0, tdo_bit);
			crc_got[i] = tdo_bit;
		end
		if (crc_got !== crc_exp) begin
			report_mismatch("module_tdo_o read CRC", crc_got, crc_exp);
		end
		tick(TAP_UPD, 1'b0, tdo_bit);
		tick(TAP_IDLE, 1'b0, tdo_bit);
		if (top_inhibit !== 1'b0) begin
			report_mismatch("top_inhibit_o", top_inhibit, 0);
		end
	endtask

	task automatic reset_readout();
		int errs_at_start;
		logic tdo_bit;
		logic [ERR_REG_WIDTH-1:0] val;
		errs_at_start = errors;
		tick(TAP_IDLE, 1'b0, tdo_bit);
		if (tdo_bit !== 1'b0) begin
			report_mismatch("module_tdo_o", tdo_bit, 0);
		end
		if (top_inhibit !== 1'b0) begin
			report_mismatch("top_inhibit_o", top_inhibit, 0);
		end
		if (bus_req.strobe !== 1'b0) begin
			report_mismatch("bus_req_o.strobe", bus_req.strobe, 0);
		end
		shift_error_reg(val);
		if (val !== '0) begin
			report_mismatch("error register", val, 0);
		end
		close_test("idle capture after reset", errs_at_start);
	endtask

	task automatic burst_write_match();
		int errs_at_start;
		logic match;
		errs_at_start = errors;
		fill_write_words();
		write_burst(WR_ADDR, 32'h0, match);
		if (match !== 1'b1) begin
			report_mismatch("module_tdo_o CRC match", match, 1);
		end
		for (int w = 0; w < WR_WORDS; w++) begin
			if (u_mem.mem[(WR_ADDR >> 2) + w] !== wr_words[w]) begin
				report_mismatch($sformatf("mem[0x%0h]", (WR_ADDR >> 2) + w),
					u_mem.mem[(WR_ADDR >> 2) + w], wr_words[w]);
			end
		end
		close_test("burst write, good CRC", errs_at_start);
	endtask

	task automatic burst_write_bad_crc();
		int errs_at_start;
		logic match;
		errs_at_start = errors;
		write_burst(WR_ADDR, 32'h0000_0400, match);
		if (match !== 1'b0) begin
			report_mismatch("module_tdo_o CRC match", match, 0);
		end
		close_test("burst write, bad CRC", errs_at_start);
	endtask

	task automatic burst_read_sizes();
		int errs_at_start;
		errs_at_start = errors;
		read_burst(OP_BREAD8, 32'h200, 4, 8);
		read_burst(OP_BREAD16, 32'h204, 2, 16);
		close_test("burst read 8 and 16 bit", errs_at_start);
	endtask

	task automatic error_address_read();
		int errs_at_start;
		logic [ERR_REG_WIDTH-1:0] val;
		errs_at_start = errors;
		read_burst(OP_BREAD32, ERR_ADDR, 1, 32);
		shift_error_reg(val);
		if (val !== {ERR_ADDR, 1'b1}) begin
			report_mismatch("error register", val, {ERR_ADDR, 1'b1});
		end
		close_test("read at error address", errs_at_start);
	endtask

	task automatic error_bit_clear();
		int errs_at_start;
		logic tdo_bit;
		logic [ERR_REG_WIDTH-1:0] val;
		errs_at_start = errors;
		send_command(make_command(OP_IREG_WRITE, 32'h0, 16'h0) | (64'b1 << ERR_CLR_BIT));
		tick(TAP_IDLE, 1'b0, tdo_bit);
		shift_error_reg(val);
		if (val !== {ERR_ADDR, 1'b0}) begin
			report_mismatch("error register", val, {ERR_ADDR, 1'b0});
		end
		close_test("error register clear", errs_at_start);
	endtask

	initial begin
		trstn = 1'b0;
		tdi = 1'b0;
		tap = '0;
		dr = '0;
		repeat (2) @(posedge tck_i);
		trstn <= 1'b1;
		reset_readout();
		burst_write_match();
		burst_write_bad_crc();
		burst_read_sizes();
		error_address_read();
		error_bit_clear();
		$display("Tests run %0d, tests failed %0d, check errors %0d", tests_run, tests_failed,
			errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/dbg_burst_counters.sv
`timescale 1ns/10ps
`default_nettype none

module dbg_burst_counters (
	input  logic tck_i,
	input  logic trstn_i,
	input  dbg_cmd_pkg::burst_ctl_t ctl_i,
	input  dbg_cmd_pkg::cmd_t cmd_i,
	input  dbg_cmd_pkg::bit_count_t word_bits_i,
	input  dbg_bus_pkg::word_bytes_t word_bytes_i,
	input  logic tdi_i,
	input  logic [dbg_cmd_pkg::DR_WIDTH-1:0] data_register_i,
	output dbg_bus_pkg::bus_addr_t addr_o,
	output dbg_bus_pkg::bus_data_t wdata_o,
	output logic word_zero_o,
	output logic word_last_o,
	output logic bit_max_o,
	output logic bit_32_o
);
	import dbg_cmd_pkg::*;
	import dbg_bus_pkg::*;

	word_count_t word_count;
	bit_count_t bit_count;
	bit_count_t align_shift;
	bus_data_t word_raw;

	always_ff @(posedge tck_i or negedge trstn_i) begin
		if (!trstn_i) begin
			addr_o <= '0;
		end else if (ctl_i.addr_load) begin
			addr_o <= cmd_i.addr;
		end else if (ctl_i.addr_inc) begin
			addr_o <= addr_o + bus_addr_t'(word_bytes_i);
		end
	end

	always_ff @(posedge tck_i or negedge trstn_i) begin
		if (!trstn_i) begin
			word_count <= '0;
		end else if (ctl_i.word_load) begin
			word_count <= cmd_i.count;
		end else if (ctl_i.word_dec) begin
			word_count <= word_count - word_count_t'(1);
		end
	end

	always_ff @(posedge tck_i or negedge trstn_i) begin
		if (!trstn_i) begin
			bit_count <= '0;
		end else if (ctl_i.bit_clr) begin
			bit_count <= '0;
		end else if (ctl_i.bit_inc) begin
			bit_count <= bit_count + bit_count_t'(1);
		end
	end

	assign word_zero_o = word_count == '0;
	assign word_last_o = word_count == word_count_t'(1);
	assign bit_max_o = bit_count == word_bits_i;
	assign bit_32_o = bit_count == bit_count_t'(CRC_BITS);

	// The word sits at the top of the register with its last bit still on tdi
	assign word_raw = {tdi_i, data_register_i[DR_WIDTH-1:DR_WIDTH-BUS_DATA_WIDTH+1]};
	assign align_shift = bit_count_t'(BUS_DATA_WIDTH - 1) - word_bits_i;
	assign wdata_o = word_raw >> align_shift;

	assert property (@(posedge tck_i) disable iff (!trstn_i)
		ctl_i.word_dec |-> !word_zero_o)
		else $error("Word count decremented at zero");

endmodule

`default_nettype wire

//--- verilog/dbg_burst_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module dbg_burst_ctrl (
	input  logic tck_i,
	input  logic trstn_i,
	input  dbg_bus_pkg::tap_ctl_t tap_i,
	input  dbg_cmd_pkg::cmd_t cmd_i,
	input  logic start_bit_i,
	input  logic word_zero_i,
	input  logic word_last_i,
	input  logic bit_max_i,
	input  logic bit_32_i,
	input  logic bus_ready_i,
	output dbg_cmd_pkg::burst_ctl_t ctl_o,
	output logic strobe_o,
	output dbg_cmd_pkg::tdo_sel_t tdo_sel_o,
	output logic inhibit_o,
	output logic op_load_o
);
	import dbg_cmd_pkg::*;

	typedef enum logic [3:0] {
		S_IDLE,
		S_RD_STROBE,
		S_RD_WAIT_CAP,
		S_RD_STATUS,
		S_RD_SHIFT,
		S_RD_CRC,
		S_WR_WAIT_CAP,
		S_WR_WAIT_START,
		S_WR_SHIFT,
		S_WR_CRC,
		S_WR_MATCH
	} state_t;

	state_t state;
	state_t state_nxt;
	logic cmd_update;
	logic burst_rd;
	logic burst_wr;
	logic rd_load;

	assign cmd_update = tap_i.select && tap_i.update && cmd_i.valid_cmd;
	assign burst_rd = cmd_i.op inside {OP_BREAD8, OP_BREAD16, OP_BREAD32};
	assign burst_wr = cmd_i.op inside {OP_BWRITE8, OP_BWRITE16, OP_BWRITE32};

	always_ff @(posedge tck_i or negedge trstn_i) begin
		if (!trstn_i) begin
			state <= S_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		ctl_o = '0;
		strobe_o = 1'b0;
		tdo_sel_o = TDO_SHIFT;
		inhibit_o = 1'b0;
		op_load_o = 1'b0;
		rd_load = 1'b0;
		case (state)
			S_IDLE: begin
				ctl_o.out_shift = tap_i.select && tap_i.shift; // Error register readout
				ctl_o.err_clr = cmd_update && cmd_i.op == OP_IREG_WRITE;
				if (cmd_update && (burst_rd || burst_wr)) begin
					state_nxt = burst_rd ? S_RD_STROBE : S_WR_WAIT_CAP;
					ctl_o.addr_load = 1'b1;
					ctl_o.word_load = 1'b1;
					ctl_o.bit_clr = 1'b1;
					ctl_o.crc_clr = 1'b1;
					op_load_o = 1'b1;
				end
			end
			S_RD_STROBE: begin
				if (word_zero_i) begin
					state_nxt = S_IDLE;
				end else begin
					strobe_o = 1'b1; // First read goes out before the host captures
					ctl_o.addr_inc = 1'b1;
					state_nxt = S_RD_WAIT_CAP;
				end
			end
			S_RD_WAIT_CAP: begin
				if (tap_i.update) begin
					state_nxt = S_IDLE;
				end else if (tap_i.select && tap_i.capture) begin
					state_nxt = S_RD_STATUS;
				end
			end
			S_RD_STATUS: begin
				tdo_sel_o = TDO_READY;
				inhibit_o = 1'b1;
				if (tap_i.update) begin
					state_nxt = S_IDLE;
				end else if (bus_ready_i) begin
					rd_load = 1'b1;
					state_nxt = S_RD_SHIFT;
				end
			end
			S_RD_SHIFT: begin
				inhibit_o = 1'b1;
				ctl_o.out_shift = 1'b1;
				ctl_o.bit_inc = 1'b1;
				ctl_o.crc_en = 1'b1;
				if (tap_i.update) begin
					state_nxt = S_IDLE;
				end else if (bit_max_i) begin
					if (word_zero_i) begin
						state_nxt = S_RD_CRC;
					end else begin
						rd_load = 1'b1;
					end
				end
			end
			S_RD_CRC: begin
				tdo_sel_o = TDO_CRC;
				inhibit_o = 1'b1;
				ctl_o.crc_shift = 1'b1;
				if (tap_i.update) begin
					state_nxt = S_IDLE;
				end
			end
			S_WR_WAIT_CAP: begin
				if (word_zero_i || tap_i.update) begin
					state_nxt = S_IDLE;
				end else if (tap_i.select && tap_i.capture) begin
					state_nxt = S_WR_WAIT_START;
				end
			end
			S_WR_WAIT_START: begin
				inhibit_o = 1'b1;
				if (tap_i.update) begin
					state_nxt = S_IDLE;
				end else if (tap_i.select && start_bit_i) begin
					// tdi already carries the first data bit here
					ctl_o.bit_inc = 1'b1;
					ctl_o.crc_en = 1'b1;
					ctl_o.crc_from_tdi = 1'b1;
					state_nxt = S_WR_SHIFT;
				end
			end
			S_WR_SHIFT: begin
				inhibit_o = 1'b1;
				ctl_o.bit_inc = 1'b1;
				ctl_o.crc_en = 1'b1;
				ctl_o.crc_from_tdi = 1'b1;
				if (tap_i.update) begin
					state_nxt = S_IDLE;
				end else if (bit_max_i) begin
					strobe_o = 1'b1; // Last bit of the word is on tdi
					ctl_o.addr_inc = 1'b1;
					ctl_o.word_dec = 1'b1;
					ctl_o.bit_clr = 1'b1;
					ctl_o.err_update = 1'b1; // Previous write must be done by now
					if (word_last_i) begin
						state_nxt = S_WR_CRC;
					end
				end
			end
			S_WR_CRC: begin
				inhibit_o = 1'b1;
				ctl_o.bit_inc = 1'b1;
				if (tap_i.update) begin
					state_nxt = S_IDLE;
				end else if (bit_32_i) begin
					tdo_sel_o = TDO_MATCH;
					state_nxt = S_WR_MATCH;
				end
			end
			S_WR_MATCH: begin
				tdo_sel_o = TDO_MATCH;
				inhibit_o = 1'b1;
				if (tap_i.update) begin
					ctl_o.err_update = 1'b1; // Checks the final write of the burst
					state_nxt = S_IDLE;
				end
			end
			default: state_nxt = S_IDLE;
		endcase
		if (rd_load) begin
			ctl_o.err_update = 1'b1;
			ctl_o.out_load_bus = 1'b1;
			ctl_o.bit_clr = 1'b1;
			ctl_o.word_dec = 1'b1;
			if (!word_last_i) begin
				strobe_o = 1'b1; // Prefetch the next word while this one shifts
				ctl_o.addr_inc = 1'b1;
			end
		end
	end

	assert property (@(posedge tck_i) disable iff (!trstn_i)
		strobe_o |=> !strobe_o)
		else $error("Bus strobe held for more than one cycle");

	assert property (@(posedge tck_i) disable iff (!trstn_i)
		(strobe_o && state == S_WR_SHIFT) |-> !word_zero_i)
		else $error("Write strobe past the end of the burst");

endmodule

`default_nettype wire

//--- verilog/dbg_bus_module.sv
`timescale 1ns/10ps
`default_nettype none

module dbg_bus_module (
	input  logic tck_i,
	input  logic trstn_i,
	input  logic tdi_i,
	input  dbg_bus_pkg::tap_ctl_t tap_i,
	input  logic [dbg_cmd_pkg::DR_WIDTH-1:0] data_register_i,
	input  dbg_bus_pkg::bus_rsp_t bus_rsp_i,
	output logic module_tdo_o,
	output logic top_inhibit_o,
	output dbg_bus_pkg::bus_req_t bus_req_o
);
	import dbg_cmd_pkg::*;
	import dbg_bus_pkg::*;

	cmd_t cmd;
	burst_ctl_t ctl;
	tdo_sel_t tdo_sel;
	bit_count_t word_bits;
	word_bytes_t word_bytes;
	logic rd_op;
	logic op_load;
	logic strobe;
	logic word_zero;
	logic word_last;
	logic bit_max;
	logic bit_32;
	logic shift_bit;
	logic [CRC_BITS-1:0] crc;
	logic crc_serial;
	bus_addr_t addr;
	bus_data_t wdata;

	assign bus_req_o.strobe = strobe;
	assign bus_req_o.write = !rd_op;
	assign bus_req_o.size = word_bytes;
	assign bus_req_o.addr = addr;
	assign bus_req_o.wdata = wdata;

	dbg_cmd_decode u_cmd_decode (
		.tck_i(tck_i),
		.trstn_i(trstn_i),
		.data_register_i(data_register_i),
		.cmd_o(cmd),
		.word_bits_o(word_bits),
		.word_bytes_o(word_bytes),
		.rd_op_o(rd_op),
		.op_load_i(op_load)
	);

	dbg_burst_ctrl u_burst_ctrl (
		.tck_i(tck_i),
		.trstn_i(trstn_i),
		.tap_i(tap_i),
		.cmd_i(cmd),
		.start_bit_i(data_register_i[DR_WIDTH-1]),
		.word_zero_i(word_zero),
		.word_last_i(word_last),
		.bit_max_i(bit_max),
		.bit_32_i(bit_32),
		.bus_ready_i(bus_rsp_i.ready),
		.ctl_o(ctl),
		.strobe_o(strobe),
		.tdo_sel_o(tdo_sel),
		.inhibit_o(top_inhibit_o),
		.op_load_o(op_load)
	);

	dbg_burst_counters u_burst_counters (
		.tck_i(tck_i),
		.trstn_i(trstn_i),
		.ctl_i(ctl),
		.cmd_i(cmd),
		.word_bits_i(word_bits),
		.word_bytes_i(word_bytes),
		.tdi_i(tdi_i),
		.data_register_i(data_register_i),
		.addr_o(addr),
		.wdata_o(wdata),
		.word_zero_o(word_zero),
		.word_last_o(word_last),
		.bit_max_o(bit_max),
		.bit_32_o(bit_32)
	);

	dbg_crc32 u_crc32 (
		.tck_i(tck_i),
		.trstn_i(trstn_i),
		.data_i(shift_bit),
		.clr_i(ctl.crc_clr),
		.en_i(ctl.crc_en),
		.shift_i(ctl.crc_shift),
		.crc_o(crc),
		.serial_o(crc_serial)
	);

	dbg_result_out u_result_out (
		.tck_i(tck_i),
		.trstn_i(trstn_i),
		.tap_i(tap_i),
		.tdi_i(tdi_i),
		.ctl_i(ctl),
		.bus_rsp_i(bus_rsp_i),
		.addr_i(addr),
		.strobe_i(strobe),
		.data_register_i(data_register_i),
		.crc_i(crc),
		.crc_serial_i(crc_serial),
		.tdo_sel_i(tdo_sel),
		.err_clr_i(data_register_i[ERR_CLR_BIT]),
		.shift_bit_o(shift_bit),
		.tdo_o(module_tdo_o)
	);

endmodule

`default_nettype wire

//--- verilog/dbg_bus_pkg.sv
`default_nettype none

package dbg_bus_pkg;

	localparam int BUS_ADDR_WIDTH = 32;
	localparam int BUS_DATA_WIDTH = 32;

	typedef logic [BUS_ADDR_WIDTH-1:0] bus_addr_t;
	typedef logic [BUS_DATA_WIDTH-1:0] bus_data_t;
	typedef logic [2:0] word_bytes_t;

	typedef struct packed {
		logic strobe; // One-cycle pulse
		logic write;
		word_bytes_t size; // Access size in bytes
		bus_addr_t addr;
		bus_data_t wdata;
	} bus_req_t;

	typedef struct packed {
		logic ready; // Level, low while an access is in flight
		logic err;
		bus_data_t rdata;
	} bus_rsp_t;

	typedef struct packed {
		logic capture;
		logic shift;
		logic update;
		logic select;
	} tap_ctl_t;

endpackage

`default_nettype wire

//--- verilog/dbg_cmd_decode.sv
`timescale 1ns/10ps
`default_nettype none

module dbg_cmd_decode (
	input  logic tck_i,
	input  logic trstn_i,
	input  logic [dbg_cmd_pkg::DR_WIDTH-1:0] data_register_i,
	output dbg_cmd_pkg::cmd_t cmd_o,
	output dbg_cmd_pkg::bit_count_t word_bits_o,
	output dbg_bus_pkg::word_bytes_t word_bytes_o,
	output logic rd_op_o,
	input  logic op_load_i
);
	import dbg_cmd_pkg::*;
	import dbg_bus_pkg::*;

	op_t op_in;
	op_t op_q;
	logic burst_op;

	assign op_in = data_register_i[OP_MSB:OP_LSB];
	assign burst_op = op_in inside {OP_BWRITE8, OP_BWRITE16, OP_BWRITE32,
		OP_BREAD8, OP_BREAD16, OP_BREAD32};

	assign cmd_o.valid_cmd = !data_register_i[CMD_BIT] && (burst_op || op_in == OP_IREG_WRITE);
	assign cmd_o.op = op_in;
	assign cmd_o.addr = data_register_i[ADDR_MSB:ADDR_LSB];
	assign cmd_o.count = data_register_i[CNT_MSB:CNT_LSB];

	always_ff @(posedge tck_i or negedge trstn_i) begin
		if (!trstn_i) begin
			op_q <= '0;
		end else if (op_load_i) begin
			op_q <= op_in;
		end
	end

	always_comb begin
		case (op_q)
			OP_BWRITE8, OP_BREAD8: word_bits_o = WORD_BITS_8;
			OP_BWRITE16, OP_BREAD16: word_bits_o = WORD_BITS_16;
			OP_BWRITE32, OP_BREAD32: word_bits_o = WORD_BITS_32;
			default: word_bits_o = '0;
		endcase
	end

	assign rd_op_o = op_q inside {OP_BREAD8, OP_BREAD16, OP_BREAD32};
	assign word_bytes_o = word_bytes_t'((word_bits_o + bit_count_t'(1)) >> 3); // 8, 16 or 32 bits

endmodule

`default_nettype wire

//--- verilog/dbg_cmd_pkg.sv
`default_nettype none

package dbg_cmd_pkg;

	localparam int DR_WIDTH = 64;

	// Command fields inside the TAP data register
	localparam int CMD_BIT = 63;
	localparam int OP_MSB = 62;
	localparam int OP_LSB = 59;
	localparam int ADDR_MSB = 58;
	localparam int ADDR_LSB = 27;
	localparam int CNT_MSB = 26;
	localparam int CNT_LSB = 11;
	localparam int ERR_CLR_BIT = 46;

	localparam int CRC_BITS = 32;
	localparam logic [CRC_BITS-1:0] CRC_POLY = 32'hEDB88320; // Reflected CRC-32 polynomial
	localparam int ERR_REG_WIDTH = 33; // Sticky error bit plus last bus address

	typedef logic [3:0] op_t;
	typedef logic [CNT_MSB-CNT_LSB:0] word_count_t;
	typedef logic [5:0] bit_count_t;

	localparam op_t OP_BWRITE8 = 4'h1;
	localparam op_t OP_BWRITE16 = 4'h2;
	localparam op_t OP_BWRITE32 = 4'h3;
	localparam op_t OP_BREAD8 = 4'h5;
	localparam op_t OP_BREAD16 = 4'h6;
	localparam op_t OP_BREAD32 = 4'h7;
	localparam op_t OP_IREG_WRITE = 4'h9;

	// Index of the last bit of a word
	localparam bit_count_t WORD_BITS_8 = 6'd7;
	localparam bit_count_t WORD_BITS_16 = 6'd15;
	localparam bit_count_t WORD_BITS_32 = 6'd31;

	typedef struct packed {
		logic valid_cmd;
		op_t op;
		logic [ADDR_MSB-ADDR_LSB:0] addr;
		word_count_t count;
	} cmd_t;

	typedef enum logic [1:0] {
		TDO_READY,
		TDO_SHIFT,
		TDO_MATCH,
		TDO_CRC
	} tdo_sel_t;

	typedef struct packed {
		logic addr_load;
		logic addr_inc;
		logic word_load;
		logic word_dec;
		logic bit_clr;
		logic bit_inc;
		logic out_load_bus;
		logic out_shift;
		logic crc_clr;
		logic crc_en;
		logic crc_from_tdi;
		logic crc_shift;
		logic err_update;
		logic err_clr;
	} burst_ctl_t;

endpackage

`default_nettype wire

//--- verilog/dbg_crc32.sv
`timescale 1ns/10ps
`default_nettype none

module dbg_crc32 (
	input  logic tck_i,
	input  logic trstn_i,
	input  logic data_i,
	input  logic clr_i,
	input  logic en_i,
	input  logic shift_i,
	output logic [dbg_cmd_pkg::CRC_BITS-1:0] crc_o,
	output logic serial_o
);
	import dbg_cmd_pkg::*;

	logic feedback;

	assign feedback = crc_o[0] ^ data_i; // LSB-first input

	always_ff @(posedge tck_i or negedge trstn_i) begin
		if (!trstn_i) begin
			crc_o <= '1;
		end else if (clr_i) begin
			crc_o <= '1;
		end else if (en_i) begin
			crc_o <= (crc_o >> 1) ^ ({CRC_BITS{feedback}} & CRC_POLY);
		end else if (shift_i) begin
			crc_o <= crc_o >> 1; // Readout, no final inversion
		end
	end

	assign serial_o = crc_o[0];

endmodule

`default_nettype wire

//--- verilog/dbg_result_out.sv
`timescale 1ns/10ps
`default_nettype none

module dbg_result_out (
	input  logic tck_i,
	input  logic trstn_i,
	input  dbg_bus_pkg::tap_ctl_t tap_i,
	input  logic tdi_i,
	input  dbg_cmd_pkg::burst_ctl_t ctl_i,
	input  dbg_bus_pkg::bus_rsp_t bus_rsp_i,
	input  dbg_bus_pkg::bus_addr_t addr_i,
	input  logic strobe_i,
	input  logic [dbg_cmd_pkg::DR_WIDTH-1:0] data_register_i,
	input  logic [dbg_cmd_pkg::CRC_BITS-1:0] crc_i,
	input  logic crc_serial_i,
	input  dbg_cmd_pkg::tdo_sel_t tdo_sel_i,
	input  logic err_clr_i,
	output logic shift_bit_o,
	output logic tdo_o
);
	import dbg_cmd_pkg::*;

	logic [ERR_REG_WIDTH-1:0] out_sr;
	logic [ERR_REG_WIDTH-1:0] err_reg; // Bit 0 sticky error, upper bits last address
	logic crc_match;

	// A read burst reloads from the bus before its first shift, so a capture may load here
	always_ff @(posedge tck_i or negedge trstn_i) begin
		if (!trstn_i) begin
			out_sr <= '0;
		end else if (ctl_i.out_load_bus) begin
			out_sr <= ERR_REG_WIDTH'(bus_rsp_i.rdata);
		end else if (tap_i.select && tap_i.capture) begin
			out_sr <= err_reg;
		end else if (ctl_i.out_shift) begin
			out_sr <= {1'b0, out_sr[ERR_REG_WIDTH-1:1]};
		end
	end

	always_ff @(posedge tck_i or negedge trstn_i) begin
		if (!trstn_i) begin
			err_reg <= '0;
		end else if (ctl_i.err_clr) begin
			if (err_clr_i) begin
				err_reg[0] <= 1'b0;
			end
		end else if (!err_reg[0]) begin
			if (ctl_i.err_update && (bus_rsp_i.err || !bus_rsp_i.ready)) begin
				err_reg[0] <= 1'b1; // Address of the failing access stays frozen
			end else if (strobe_i) begin
				err_reg[ERR_REG_WIDTH-1:1] <= addr_i;
			end
		end
	end

	assign shift_bit_o = ctl_i.crc_from_tdi ? tdi_i : out_sr[0];
	assign crc_match = data_register_i[DR_WIDTH-1:DR_WIDTH-CRC_BITS] == crc_i;

	always_comb begin
		case (tdo_sel_i)
			TDO_READY: tdo_o = bus_rsp_i.ready;
			TDO_SHIFT: tdo_o = out_sr[0];
			TDO_MATCH: tdo_o = crc_match;
			default: tdo_o = crc_serial_i;
		endcase
	end

endmodule

`default_nettype wire
